//--- design/mips_isa_pkg.sv
package mips_isa_pkg;

	// instruction field widths of the 32-bit MIPS word
	localparam int opcode_w = 6;
	localparam int funct_w = 6;
	localparam int imm_w = 16;
	localparam int target_w = 26;

	// primary opcodes that the execution unit recognises
	typedef enum logic [opcode_w-1:0] {
		op_special = 6'h00,
		op_jal     = 6'h03,
		op_addi    = 6'h08,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f
	} opcode_e;

	// function codes of the special (R-type) opcode
	typedef enum logic [funct_w-1:0] {
		fn_sll     = 6'h00,
		fn_srl     = 6'h02,
		fn_syscall = 6'h0c,
		fn_add     = 6'h20,
		fn_addu    = 6'h21,
		fn_sub     = 6'h22,
		fn_and     = 6'h24,
		fn_or      = 6'h25,
		fn_xor     = 6'h26,
		fn_nor     = 6'h27,
		fn_slt     = 6'h2a
	} funct_e;

	// architectural register numbers with a fixed role
	localparam logic [4:0] reg_zero = 5'd0;
	localparam logic [4:0] reg_v0 = 5'd2;
	localparam logic [4:0] reg_a0 = 5'd4;
	localparam logic [4:0] reg_sp = 5'd29;
	localparam logic [4:0] reg_ra = 5'd31;

endpackage

//--- design/core_pkg.sv
package core_pkg;

	// datapath word width and register index width
	localparam int data_w = 32;
	localparam int addr_w = 5;
	// number of general purpose registers
	localparam int reg_count = 32;

	// operations the ALU can perform
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_lui
	} alu_op_e;

	// broad instruction class, it also steers the register file read ports
	typedef enum logic [1:0] {
		cls_alu,
		cls_jal,
		cls_syscall,
		cls_illegal
	} instr_class_e;

	// handshake sequencer states
	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_exec,
		st_ack
	} seq_state_e;

endpackage

//--- design/reg_port_if.sv
`timescale 1ns/1ns

interface reg_port_if;

	// read side, two ports addressed by rs and rt
	logic [core_pkg::addr_w-1:0] rs;
	logic [core_pkg::addr_w-1:0] rt;
	// class of the current instruction, selects the read override
	core_pkg::instr_class_e read_sel;
	logic [core_pkg::data_w-1:0] pc_plus_4;
	logic read_en;
	logic [core_pkg::data_w-1:0] read_data_1;
	logic [core_pkg::data_w-1:0] read_data_2;

	// single synchronous write port
	logic wr_en;
	logic [core_pkg::addr_w-1:0] wr_addr;
	logic [core_pkg::data_w-1:0] wr_data;

	// the sequencer issues reads and writes
	modport seq (
		output rs, rt, read_sel, pc_plus_4, read_en,
		output wr_en, wr_addr, wr_data,
		input read_data_1, read_data_2
	);

	// the register file serves them
	modport rf (
		input rs, rt, read_sel, pc_plus_4, read_en,
		input wr_en, wr_addr, wr_data,
		output read_data_1, read_data_2
	);

endinterface

//--- design/mips_regfile.sv
`timescale 1ns/1ns

module mips_regfile #(
	parameter logic [31:0] stack_top = 32'h0000_3ffc
) (
	input logic clk,
	input logic rst,
	reg_port_if.rf port
);

	logic [core_pkg::data_w-1:0] regs [core_pkg::reg_count];

	// write port, r0 is never written so it stays at its reset value of zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < core_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
			// the stack pointer starts at the top of the stack region
			regs[mips_isa_pkg::reg_sp] <= stack_top;
		end else if (port.wr_en && port.wr_addr != mips_isa_pkg::reg_zero) begin
			regs[port.wr_addr] <= port.wr_data;
		end
	end

	// registered read ports
	// syscall reads v0 and a0 regardless of the instruction fields
	// jal reads the return address on port 1 and zero on port 2
	always_ff @(posedge clk) begin
		if (port.read_en) begin
			case (port.read_sel)
				core_pkg::cls_syscall: begin
					port.read_data_1 <= regs[mips_isa_pkg::reg_v0];
					port.read_data_2 <= regs[mips_isa_pkg::reg_a0];
				end
				core_pkg::cls_jal: begin
					port.read_data_1 <= port.pc_plus_4;
					port.read_data_2 <= regs[mips_isa_pkg::reg_zero];
				end
				default: begin
					port.read_data_1 <= regs[port.rs];
					port.read_data_2 <= regs[port.rt];
				end
			endcase
		end
	end

	// a normal read of r0 on either port returns zero one cycle later
	a_r0_rs_zero: assert property (@(posedge clk) disable iff (rst)
		port.read_en && port.read_sel inside {core_pkg::cls_alu, core_pkg::cls_illegal}
		&& port.rs == mips_isa_pkg::reg_zero |=> port.read_data_1 == '0);
	a_r0_rt_zero: assert property (@(posedge clk) disable iff (rst)
		port.read_en && port.read_sel inside {core_pkg::cls_alu, core_pkg::cls_illegal}
		&& port.rt == mips_isa_pkg::reg_zero |=> port.read_data_2 == '0);

	// the sequencer must never read and write in the same cycle
	a_no_rw_overlap: assert property (@(posedge clk) disable iff (rst)
		!(port.wr_en && port.read_en));

endmodule

//--- design/mips_decoder.sv
`timescale 1ns/1ns

module mips_decoder (
	input logic [31:0] instr,
	output logic [4:0] rs,
	output logic [4:0] rt,
	output logic [4:0] dest,
	output logic [31:0] imm,
	output logic use_imm,
	output logic [4:0] shamt,
	output core_pkg::alu_op_e alu_op,
	output core_pkg::instr_class_e cls
);

	mips_isa_pkg::opcode_e opcode;
	mips_isa_pkg::funct_e funct;
	logic [4:0] rd;
	logic [core_pkg::data_w-1:0] imm_sext;
	logic [core_pkg::data_w-1:0] imm_zext;

	// fixed instruction fields
	assign opcode = mips_isa_pkg::opcode_e'(instr[31:26]);
	assign funct = mips_isa_pkg::funct_e'(instr[5:0]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];

	// both extensions of the 16-bit immediate
	assign imm_sext = {{(core_pkg::data_w - mips_isa_pkg::imm_w){instr[15]}},
		instr[mips_isa_pkg::imm_w-1:0]};
	assign imm_zext = {{(core_pkg::data_w - mips_isa_pkg::imm_w){1'b0}},
		instr[mips_isa_pkg::imm_w-1:0]};

	always_comb begin
		// anything not matched below is illegal and writes nothing
		alu_op = core_pkg::alu_add;
		cls = core_pkg::cls_illegal;
		dest = mips_isa_pkg::reg_zero;
		use_imm = 1'b0;
		imm = imm_sext;
		case (opcode)
			mips_isa_pkg::op_special: begin
				// R-type writes rd, syscall only reads
				cls = core_pkg::cls_alu;
				dest = rd;
				case (funct)
					mips_isa_pkg::fn_add: alu_op = core_pkg::alu_add;
					mips_isa_pkg::fn_addu: alu_op = core_pkg::alu_add;
					mips_isa_pkg::fn_sub: alu_op = core_pkg::alu_sub;
					mips_isa_pkg::fn_and: alu_op = core_pkg::alu_and;
					mips_isa_pkg::fn_or: alu_op = core_pkg::alu_or;
					mips_isa_pkg::fn_xor: alu_op = core_pkg::alu_xor;
					mips_isa_pkg::fn_nor: alu_op = core_pkg::alu_nor;
					mips_isa_pkg::fn_slt: alu_op = core_pkg::alu_slt;
					mips_isa_pkg::fn_sll: alu_op = core_pkg::alu_sll;
					mips_isa_pkg::fn_srl: alu_op = core_pkg::alu_srl;
					mips_isa_pkg::fn_syscall: begin
						cls = core_pkg::cls_syscall;
						dest = mips_isa_pkg::reg_zero;
					end
					default: begin
						cls = core_pkg::cls_illegal;
						dest = mips_isa_pkg::reg_zero;
					end
				endcase
			end
			mips_isa_pkg::op_jal: begin
				// the link value arrives through the read override
				cls = core_pkg::cls_jal;
				dest = mips_isa_pkg::reg_ra;
			end
			default: begin
				// I-type, result goes to rt
				cls = core_pkg::cls_alu;
				dest = rt;
				use_imm = 1'b1;
				case (opcode)
					mips_isa_pkg::op_addi: alu_op = core_pkg::alu_add;
					mips_isa_pkg::op_addiu: alu_op = core_pkg::alu_add;
					mips_isa_pkg::op_slti: alu_op = core_pkg::alu_slt;
					mips_isa_pkg::op_andi: begin
						alu_op = core_pkg::alu_and;
						imm = imm_zext;
					end
					mips_isa_pkg::op_ori: begin
						alu_op = core_pkg::alu_or;
						imm = imm_zext;
					end
					mips_isa_pkg::op_xori: begin
						alu_op = core_pkg::alu_xor;
						imm = imm_zext;
					end
					mips_isa_pkg::op_lui: begin
						alu_op = core_pkg::alu_lui;
						imm = imm_zext;
					end
					default: begin
						cls = core_pkg::cls_illegal;
						dest = mips_isa_pkg::reg_zero;
						use_imm = 1'b0;
					end
				endcase
			end
		endcase
	end

endmodule

//--- design/mips_alu.sv
`timescale 1ns/1ns

module mips_alu (
	input core_pkg::alu_op_e op,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [4:0] shamt,
	output logic [31:0] y
);

	always_comb begin
		case (op)
			// add and addu differ only in trapping, which is not modelled
			core_pkg::alu_add: y = a + b;
			core_pkg::alu_sub: y = a - b;
			core_pkg::alu_and: y = a & b;
			core_pkg::alu_or: y = a | b;
			core_pkg::alu_xor: y = a ^ b;
			core_pkg::alu_nor: y = ~(a | b);
			// signed compare, result is 0 or 1
			core_pkg::alu_slt: begin
				y = {31'b0, $signed(a) < $signed(b)};
			end
			// the shifts move the rt operand by the shamt field
			core_pkg::alu_sll: y = b << shamt;
			core_pkg::alu_srl: y = b >> shamt;
			// lui puts the immediate in the upper half
			core_pkg::alu_lui: y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

endmodule

//--- design/mips_sequencer.sv
`timescale 1ns/1ns

module mips_sequencer #(
	parameter logic [31:0] reset_pc = 32'h0040_0000
) (
	input logic clk,
	input logic rst,
	input logic req,
	input logic [31:0] instr,
	output logic ack,
	output logic [4:0] result_reg,
	output logic [31:0] result_data,
	output logic [31:0] aux_data,
	output logic syscall,
	output logic illegal,
	output logic [31:0] pc,
	output logic [31:0] dec_instr,
	input logic [4:0] dec_rs,
	input logic [4:0] dec_rt,
	input logic [4:0] dec_dest,
	input logic [31:0] dec_imm,
	input logic dec_use_imm,
	input core_pkg::instr_class_e dec_cls,
	output logic [31:0] alu_op_a,
	output logic [31:0] alu_op_b,
	input logic [31:0] alu_y,
	reg_port_if.seq port
);

	core_pkg::seq_state_e state;
	logic [core_pkg::data_w-1:0] wb_data;
	logic [core_pkg::data_w-1:0] pc_next;
	logic is_jal;
	logic is_sys;

	assign is_jal = dec_cls == core_pkg::cls_jal;
	assign is_sys = dec_cls == core_pkg::cls_syscall;

	// read request comes straight from the decoded latched instruction
	assign port.rs = dec_rs;
	assign port.rt = dec_rt;
	assign port.read_sel = dec_cls;
	assign port.pc_plus_4 = pc + 32'd4;
	assign port.read_en = state == core_pkg::st_read;

	// operand a is always rs, operand b is rt or the immediate
	assign alu_op_a = port.read_data_1;
	assign alu_op_b = dec_use_imm ? dec_imm : port.read_data_2;

	// for jal port 1 already carries pc+4 from the read override
	assign wb_data = is_jal ? port.read_data_1 : alu_y;

	// write back in the exec cycle only, so it never meets a read
	assign port.wr_en = state == core_pkg::st_exec
		&& dec_cls inside {core_pkg::cls_alu, core_pkg::cls_jal};
	assign port.wr_addr = dec_dest;
	assign port.wr_data = wb_data;

	// jal keeps the 256 MB region of pc+4 and takes the word target
	assign pc_next = is_jal
		? {port.pc_plus_4[31:28], dec_instr[mips_isa_pkg::target_w-1:0], 2'b00}
		: port.pc_plus_4;

	// control state
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= core_pkg::st_idle;
			ack <= 1'b0;
			syscall <= 1'b0;
			illegal <= 1'b0;
			pc <= reset_pc;
		end else begin
			case (state)
				core_pkg::st_idle: begin
					if (req) begin
						state <= core_pkg::st_read;
					end
				end
				// the register file captures its operands on this edge
				core_pkg::st_read: state <= core_pkg::st_exec;
				core_pkg::st_exec: begin
					state <= core_pkg::st_ack;
					ack <= 1'b1;
					syscall <= is_sys;
					illegal <= dec_cls == core_pkg::cls_illegal;
					pc <= pc_next;
				end
				// hold ack until the host lets go of req
				core_pkg::st_ack: begin
					if (!req) begin
						state <= core_pkg::st_idle;
						ack <= 1'b0;
					end
				end
				default: state <= core_pkg::st_idle;
			endcase
		end
	end

	// instruction latch and result registers
	always_ff @(posedge clk) begin
		if (state == core_pkg::st_idle && req) begin
			dec_instr <= instr;
		end
		if (state == core_pkg::st_exec) begin
			result_reg <= dec_dest;
			// syscall shows v0 here and a0 on the aux path
			if (is_sys) begin
				result_data <= port.read_data_1;
			end else if (dec_cls == core_pkg::cls_illegal) begin
				result_data <= '0;
			end else begin
				result_data <= wb_data;
			end
			aux_data <= is_sys ? port.read_data_2 : '0;
		end
	end

	// the host must still hold req at the edge where ack goes up
	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req));

endmodule

//--- design/mips_exec_top.sv
`timescale 1ns/1ns

module mips_exec_top #(
	parameter logic [31:0] stack_top = 32'h0000_3ffc,
	parameter logic [31:0] reset_pc = 32'h0040_0000
) (
	input logic clk,
	input logic rst,
	input logic req,
	input logic [31:0] instr,
	output logic ack,
	output logic [4:0] result_reg,
	output logic [31:0] result_data,
	output logic [31:0] aux_data,
	output logic syscall,
	output logic illegal,
	output logic [31:0] pc
);

	logic [31:0] dec_instr;
	logic [4:0] dec_rs;
	logic [4:0] dec_rt;
	logic [4:0] dec_dest;
	logic [31:0] dec_imm;
	logic dec_use_imm;
	logic [4:0] dec_shamt;
	core_pkg::alu_op_e dec_alu_op;
	core_pkg::instr_class_e dec_cls;
	logic [31:0] alu_op_a;
	logic [31:0] alu_op_b;
	logic [31:0] alu_y;

	// register file access bundle between sequencer and register file
	reg_port_if rp ();

	mips_regfile #(
		.stack_top(stack_top)
	) u_regfile (
		.clk(clk),
		.rst(rst),
		.port(rp.rf)
	);

	// decodes the instruction held by the sequencer
	mips_decoder u_decoder (
		.instr(dec_instr),
		.rs(dec_rs),
		.rt(dec_rt),
		.dest(dec_dest),
		.imm(dec_imm),
		.use_imm(dec_use_imm),
		.shamt(dec_shamt),
		.alu_op(dec_alu_op),
		.cls(dec_cls)
	);

	// operation and shift amount come from the decoder, operands from the sequencer
	mips_alu u_alu (
		.op(dec_alu_op),
		.a(alu_op_a),
		.b(alu_op_b),
		.shamt(dec_shamt),
		.y(alu_y)
	);

	mips_sequencer #(
		.reset_pc(reset_pc)
	) u_sequencer (
		.clk(clk),
		.rst(rst),
		.req(req),
		.instr(instr),
		.ack(ack),
		.result_reg(result_reg),
		.result_data(result_data),
		.aux_data(aux_data),
		.syscall(syscall),
		.illegal(illegal),
		.pc(pc),
		.dec_instr(dec_instr),
		.dec_rs(dec_rs),
		.dec_rt(dec_rt),
		.dec_dest(dec_dest),
		.dec_imm(dec_imm),
		.dec_use_imm(dec_use_imm),
		.dec_cls(dec_cls),
		.alu_op_a(alu_op_a),
		.alu_op_b(alu_op_b),
		.alu_y(alu_y),
		.port(rp.seq)
	);

endmodule

//--- tests/mips_ref_model.svh
// reference model of the architectural state that the host can observe
// it tracks the register array and the program counter, one instruction at a time
logic [31:0] model_regs [32];
logic [31:0] model_pc;

// expected outputs of the most recent instruction
logic [4:0] exp_reg;
logic [31:0] exp_data;
logic [31:0] exp_aux;
logic exp_sys;
logic exp_ill;

// after reset every register is zero except the stack pointer
function automatic void model_reset();
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = '0;
	end
	model_regs[mips_isa_pkg::reg_sp] = stack_top;
	model_pc = reset_pc;
endfunction

// applies one instruction word to the model and sets the expected outputs
function automatic void model_step(input logic [31:0] word);
	logic [5:0] opc;
	logic [5:0] fn;
	logic [4:0] rs_i;
	logic [4:0] rt_i;
	logic [4:0] rd_i;
	logic [4:0] sh;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sext;
	logic [31:0] zext;
	logic [31:0] res;
	logic [31:0] link;
	opc = word[31:26];
	fn = word[5:0];
	rs_i = word[25:21];
	rt_i = word[20:16];
	rd_i = word[15:11];
	sh = word[10:6];
	a = model_regs[rs_i];
	b = model_regs[rt_i];
	sext = {{16{word[15]}}, word[15:0]};
	zext = {16'h0000, word[15:0]};
	link = model_pc + 32'd4;
	res = '0;
	exp_reg = 5'd0;
	exp_aux = '0;
	exp_sys = 1'b0;
	exp_ill = 1'b0;
	case (opc)
		mips_isa_pkg::op_special: begin
			exp_reg = rd_i;
			case (fn)
				mips_isa_pkg::fn_add, mips_isa_pkg::fn_addu: res = a + b;
				mips_isa_pkg::fn_sub: res = a - b;
				mips_isa_pkg::fn_and: res = a & b;
				mips_isa_pkg::fn_or: res = a | b;
				mips_isa_pkg::fn_xor: res = a ^ b;
				mips_isa_pkg::fn_nor: res = ~(a | b);
				mips_isa_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				mips_isa_pkg::fn_sll: res = b << sh;
				mips_isa_pkg::fn_srl: res = b >> sh;
				mips_isa_pkg::fn_syscall: begin
					// syscall reports v0 with a0 on the side and writes nothing
					exp_sys = 1'b1;
					exp_reg = 5'd0;
					res = model_regs[mips_isa_pkg::reg_v0];
					exp_aux = model_regs[mips_isa_pkg::reg_a0];
				end
				default: begin
					exp_ill = 1'b1;
					exp_reg = 5'd0;
				end
			endcase
		end
		mips_isa_pkg::op_jal: begin
			exp_reg = mips_isa_pkg::reg_ra;
			res = link;
		end
		mips_isa_pkg::op_addi, mips_isa_pkg::op_addiu: begin
			exp_reg = rt_i;
			res = a + sext;
		end
		mips_isa_pkg::op_slti: begin
			exp_reg = rt_i;
			res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
		end
		mips_isa_pkg::op_andi: begin
			exp_reg = rt_i;
			res = a & zext;
		end
		mips_isa_pkg::op_ori: begin
			exp_reg = rt_i;
			res = a | zext;
		end
		mips_isa_pkg::op_xori: begin
			exp_reg = rt_i;
			res = a ^ zext;
		end
		mips_isa_pkg::op_lui: begin
			exp_reg = rt_i;
			res = {word[15:0], 16'h0000};
		end
		default: exp_ill = 1'b1;
	endcase
	// r0 reports the computed value but keeps holding zero
	if (!exp_sys && !exp_ill && exp_reg != 5'd0) begin
		model_regs[exp_reg] = res;
	end
	exp_data = exp_ill ? 32'd0 : res;
	// jal keeps the top four bits of pc+4, everything else steps by one word
	if (opc == mips_isa_pkg::op_jal) begin
		model_pc = {link[31:28], word[25:0], 2'b00};
	end else begin
		model_pc = link;
	end
endfunction

//--- tests/tb_mips_exec.sv
`timescale 1ns/1ns

module tb_mips_exec;

	localparam logic [31:0] stack_top = 32'h0000_3ffc;
	localparam logic [31:0] reset_pc = 32'h0040_0000;
	localparam int reset_cycles = 16;
	localparam int num_random = 400;
	localparam int num_directed = 4;
	// worst case per instruction is 3 edges to ack, 3 held edges and 1 to drop
	localparam int cycles_per_instr = 8;
	localparam int cycle_limit = reset_cycles
		+ (num_random + num_directed) * cycles_per_instr + cycles_per_instr;

	logic clk;
	logic rst;
	logic req;
	logic [31:0] instr;
	logic ack;
	logic [4:0] result_reg;
	logic [31:0] result_data;
	logic [31:0] aux_data;
	logic syscall;
	logic illegal;
	logic [31:0] pc;
	int cycles;

	`include "mips_ref_model.svh"

	mips_exec_top #(
		.stack_top(stack_top),
		.reset_pc(reset_pc)
	) dut (
		.clk(clk),
		.rst(rst),
		.req(req),
		.instr(instr),
		.ack(ack),
		.result_reg(result_reg),
		.result_data(result_data),
		.aux_data(aux_data),
		.syscall(syscall),
		.illegal(illegal),
		.pc(pc)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// compares one observed value, the first wrong one ends the run
	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("mismatch %s expected %h actual %h", test_name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// a quarter of the picks land on the registers with a fixed role
	function automatic logic [4:0] pick_reg();
		logic [4:0] hot [5] = '{mips_isa_pkg::reg_zero, mips_isa_pkg::reg_v0,
			mips_isa_pkg::reg_a0, mips_isa_pkg::reg_sp, mips_isa_pkg::reg_ra};
		if ($urandom % 4 == 0) begin
			return hot[$urandom % 5];
		end
		return 5'($urandom);
	endfunction

	// mostly supported instructions, with a few unsupported opcodes and functs
	function automatic logic [31:0] random_instr();
		logic [5:0] r_functs [11] = '{6'h00, 6'h02, 6'h0c, 6'h20, 6'h21, 6'h22,
			6'h24, 6'h25, 6'h26, 6'h27, 6'h2a};
		logic [5:0] i_ops [7] = '{6'h08, 6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
		logic [5:0] bad_ops [4] = '{6'h02, 6'h04, 6'h23, 6'h2b};
		int unsigned pick;
		pick = $urandom % 100;
		if (pick < 45) begin
			return {6'h00, pick_reg(), pick_reg(), pick_reg(), 5'($urandom),
				r_functs[$urandom % 11]};
		end else if (pick < 85) begin
			return {i_ops[$urandom % 7], pick_reg(), pick_reg(), 16'($urandom)};
		end else if (pick < 92) begin
			return {6'h03, 26'($urandom)};
		end else if (pick < 96) begin
			// mult under the special opcode is not supported here
			return {6'h00, pick_reg(), pick_reg(), pick_reg(), 5'd0, 6'h18};
		end
		return {bad_ops[$urandom % 4], 26'($urandom)};
	endfunction

	// runs one four-phase handshake and checks every output against the model
	// it starts and ends one ns after a rising edge with ack low
	task automatic run_instr(input string test_name, input logic [31:0] word);
		int edges;
		int hold;
		edges = 0;
		hold = int'($urandom % 4);
		model_step(word);
		req = 1'b1;
		instr = word;
		while (!ack) begin
			@(posedge clk);
			#1;
			edges++;
		end
		// counted from the edge before the one that samples req
		check_value({test_name, " ack latency"}, 32'd3, 32'(edges));
		check_value({test_name, " result_reg"}, {27'b0, exp_reg}, {27'b0, result_reg});
		check_value({test_name, " result_data"}, exp_data, result_data);
		check_value({test_name, " aux_data"}, exp_aux, aux_data);
		check_value({test_name, " syscall"}, {31'b0, exp_sys}, {31'b0, syscall});
		check_value({test_name, " illegal"}, {31'b0, exp_ill}, {31'b0, illegal});
		check_value({test_name, " pc"}, model_pc, pc);
		// back-pressure, ack must stay up while req is held
		repeat (hold) begin
			@(posedge clk);
			#1;
			check_value({test_name, " ack hold"}, 32'd1, {31'b0, ack});
		end
		req = 1'b0;
		instr = $urandom;
		@(posedge clk);
		#1;
		check_value({test_name, " ack release"}, 32'd0, {31'b0, ack});
	endtask

	// watchdog on the total number of cycles
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the req/ack handshake hung, no progress after %0d cycles", cycles);
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(55698));
		rst = 1'b1;
		req = 1'b0;
		instr = '0;
		model_reset();
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
		check_value("reset ack", 32'd0, {31'b0, ack});
		check_value("reset pc", reset_pc, pc);

		// v0 and a0 read back as zero straight after reset
		run_instr("syscall after reset", {6'h00, 20'h00000, 6'h0c});
		check_value("syscall after reset v0", 32'd0, result_data);
		check_value("syscall after reset a0", 32'd0, aux_data);
		// or r1, r0, sp shows the reset value of the stack pointer
		run_instr("sp after reset", {6'h00, 5'd0, 5'd29, 5'd1, 5'd0, 6'h25});
		check_value("sp after reset value", stack_top, result_data);
		// addi r0, r0, 0x1234 reports its sum but must not stick
		run_instr("write to r0", {6'h08, 5'd0, 5'd0, 16'h1234});
		check_value("write to r0 value", 32'h0000_1234, result_data);
		run_instr("read of r0", {6'h00, 5'd0, 5'd0, 5'd3, 5'd0, 6'h25});
		check_value("read of r0 value", 32'd0, result_data);

		for (int i = 0; i < num_random; i++) begin
			run_instr($sformatf("random %0d", i), random_instr());
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- sources.f
+incdir+tests
design/mips_isa_pkg.sv
design/core_pkg.sv
design/reg_port_if.sv
design/mips_regfile.sv
design/mips_decoder.sv
design/mips_alu.sv
design/mips_sequencer.sv
design/mips_exec_top.sv
tests/tb_mips_exec.sv

//--- run.sh
#!/bin/bash
# builds the testbench with Verilator, runs it and judges the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mips_exec -f sources.f
./obj_dir/Vtb_mips_exec > sim.log 2>&1 || true
cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
# a run that ended without either message also counts as a failure
grep -q "SIMULATION PASSED" sim.log
